// ==== common/mips_exc_macros.svh ====
`ifndef MIPS_EXC_MACROS_SVH
`define MIPS_EXC_MACROS_SVH

// single exception entry, no BEV or TLB refill offsets
`define EXC_ENTRY 32'hBFC0_0380

// CP0 register numbers, select 0 only
`define CP0_BADVADDR 5'd8
`define CP0_COUNT    5'd9
`define CP0_COMPARE  5'd11
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// Count advances once every this many clocks
`define COUNT_PRESCALE 2

`endif

// ==== common/mips_exc_pkg.sv ====
package mips_exc_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // Cause.ExcCode values this core can raise
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12
    } exc_code_t;

    // Status register view, unused bits stay zero
    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  IM;
        logic [4:0]  zero_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    // exception record handed from the prioritizer to the sequencer and CP0
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        word_t     badvaddr;
        logic      in_delay_slot;
        word_t     location;
    } exception_t;

    // address errors are the only causes that update BadVAddr
    function automatic logic is_addr_err(input exc_code_t code);
        logic hit;
        hit = (code == CODE_ADEL) || (code == CODE_ADES);
        return hit;
    endfunction

    // Status as seen right after reset
    function automatic cp0_status_t status_reset_value();
        cp0_status_t s;
        s = '0;
        s.ERL = 1'b1;
        return s;
    endfunction

    // EPC points back at the branch when the fault sits in a delay slot
    function automatic word_t epc_of(input word_t pc, input logic in_delay_slot);
        word_t r;
        r = in_delay_slot ? (pc - 32'd4) : pc;
        return r;
    endfunction

endpackage

// ==== exception/exception.sv ====
`timescale 1ns/1ps

`include "mips_exc_macros.svh"

module exception
    import mips_exc_pkg::*;
(
    input  logic        exc_instr,
    input  logic        exc_ri,
    input  logic        exc_of,
    input  logic        exc_sys,
    input  logic        exc_bp,
    input  logic        exc_load,
    input  logic        exc_save,
    input  word_t       pc,
    input  word_t       vaddr,
    input  logic        in_delay_slot,
    input  logic [7:0]  interrupt_info,
    input  cp0_status_t cp0_status,
    output exception_t  exception
);

    logic      interrupt_valid;
    logic      cause_valid;
    exc_code_t code;
    logic      fetch_fault;

    // an interrupt needs a masked request and no exception level active
    assign interrupt_valid = (interrupt_info != 8'd0)
                           & cp0_status.IE
                           & ~cp0_status.EXL
                           & ~cp0_status.ERL;

    // fixed priority, interrupt first
    always_comb begin
        cause_valid = 1'b1;
        code        = CODE_INT;
        if (interrupt_valid) begin
            code = CODE_INT;
        end else if (exc_instr) begin
            code = CODE_ADEL;
        end else if (exc_ri) begin
            code = CODE_RI;
        end else if (exc_of) begin
            code = CODE_OV;
        end else if (exc_sys) begin
            code = CODE_SYS;
        end else if (exc_bp) begin
            code = CODE_BP;
        end else if (exc_load) begin
            code = CODE_ADEL;
        end else if (exc_save) begin
            code = CODE_ADES;
        end else begin
            cause_valid = 1'b0;
        end
    end

    // fetch errors fault on the pc itself
    assign fetch_fault = ~interrupt_valid & exc_instr;

    assign exception.valid         = cause_valid;
    assign exception.code          = code;
    assign exception.pc            = pc;
    assign exception.badvaddr      = fetch_fault ? pc : vaddr;
    assign exception.in_delay_slot = in_delay_slot;
    assign exception.location      = `EXC_ENTRY;

endmodule

// ==== exception/exc_sequencer.sv ====
`timescale 1ns/1ps

module exc_sequencer
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  exception_t exception,
    input  logic       eret,
    output logic       exc_commit,
    output logic       eret_commit,
    output logic       exc_taken,
    output exc_code_t  exc_code,
    output logic       redirect_valid,
    output logic       flush
);

    typedef enum logic {
        IDLE  = 1'b0,
        DRAIN = 1'b1
    } seq_state_t;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       take_exc;
    logic       take_eret;

    // events are only accepted in IDLE, exception beats eret
    assign take_exc  = (state_q == IDLE) & exception.valid;
    assign take_eret = (state_q == IDLE) & ~exception.valid & eret;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_exc || take_eret) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // strobes towards CP0
    assign exc_commit  = take_exc;
    assign eret_commit = take_eret;

    // pipeline side
    assign exc_taken      = take_exc;
    assign exc_code       = take_exc ? exception.code : CODE_INT;
    assign redirect_valid = take_exc | take_eret;

    // flush covers the redirect cycle and the drain cycle after it
    assign flush = take_exc | take_eret | (state_q == DRAIN);

endmodule

// ==== cp0/cp0_regs.sv ====
`timescale 1ns/1ps

`include "mips_exc_macros.svh"

module cp0_regs
    import mips_exc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cp0_we,
    input  logic [4:0]  cp0_waddr,
    input  word_t       cp0_wdata,
    input  logic [4:0]  cp0_raddr,
    input  logic [5:0]  hw_int,
    input  logic        timer_irq,
    input  word_t       count,
    input  logic        exc_commit,
    input  logic        eret_commit,
    input  exception_t  exception,
    output word_t       cp0_rdata,
    output cp0_status_t cp0_status,
    output logic [7:0]  interrupt_info,
    output word_t       epc,
    output logic        compare_write
);

    cp0_status_t status_q;
    logic        cause_bd_q;
    logic [1:0]  cause_ip_sw_q;
    exc_code_t   cause_code_q;
    word_t       compare_q;
    word_t       epc_q;
    word_t       badvaddr_q;
    logic [7:0]  ip_pending;
    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;

    assign wr_status     = cp0_we & (cp0_waddr == `CP0_STATUS);
    assign wr_cause      = cp0_we & (cp0_waddr == `CP0_CAUSE);
    assign wr_epc        = cp0_we & (cp0_waddr == `CP0_EPC);
    assign compare_write = cp0_we & (cp0_waddr == `CP0_COMPARE);

    // IP7 also carries the timer
    assign ip_pending     = {hw_int[5] | timer_irq, hw_int[4:0], cause_ip_sw_q};
    assign interrupt_info = ip_pending & status_q.IM;

    // control state, an exception in the same cycle overrides MTC0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q      <= status_reset_value();
            cause_bd_q    <= 1'b0;
            cause_ip_sw_q <= 2'b00;
            cause_code_q  <= CODE_INT;
            compare_q     <= '0;
        end else begin
            if (wr_status) begin
                status_q.IM  <= cp0_wdata[15:8];
                status_q.ERL <= cp0_wdata[2];
                status_q.EXL <= cp0_wdata[1];
                status_q.IE  <= cp0_wdata[0];
            end
            if (wr_cause) begin
                cause_ip_sw_q <= cp0_wdata[9:8];
            end
            if (compare_write) begin
                compare_q <= cp0_wdata;
            end
            if (exc_commit) begin
                status_q.EXL <= 1'b1;
                cause_bd_q   <= exception.in_delay_slot;
                cause_code_q <= exception.code;
            end else if (eret_commit) begin
                status_q.EXL <= 1'b0;
            end
        end
    end

    // fault addresses
    always_ff @(posedge clk) begin
        if (wr_epc) begin
            epc_q <= cp0_wdata;
        end
        if (exc_commit) begin
            epc_q <= epc_of(exception.pc, exception.in_delay_slot);
            if (is_addr_err(exception.code)) begin
                badvaddr_q <= exception.badvaddr;
            end
        end
    end

    assign cp0_status = status_q;
    assign epc        = epc_q;

    // MFC0 read port
    always_comb begin
        case (cp0_raddr)
            `CP0_BADVADDR: cp0_rdata = badvaddr_q;
            `CP0_COUNT:    cp0_rdata = count;
            `CP0_COMPARE:  cp0_rdata = compare_q;
            `CP0_STATUS:   cp0_rdata = status_q;
            `CP0_CAUSE:    cp0_rdata = {cause_bd_q, timer_irq, 14'd0, ip_pending,
                                        1'b0, cause_code_q, 2'b00};
            `CP0_EPC:      cp0_rdata = epc_q;
            default:       cp0_rdata = '0;
        endcase
    end

endmodule

// ==== cp0/cp0_timer.sv ====
`timescale 1ns/1ps

`include "mips_exc_macros.svh"

module cp0_timer
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cp0_we,
    input  logic [4:0] cp0_waddr,
    input  word_t      cp0_wdata,
    input  logic       compare_write,
    output word_t      count,
    output logic       timer_irq
);

    localparam int PRE_W = $clog2(`COUNT_PRESCALE);

    logic [PRE_W-1:0] prescale_q;
    logic             tick;
    logic             wr_count;
    word_t            compare_q;
    logic             armed_q;

    assign wr_count = cp0_we & (cp0_waddr == `CP0_COUNT);
    assign tick     = (prescale_q == PRE_W'(`COUNT_PRESCALE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale_q <= '0;
            count      <= '0;
            compare_q  <= '0;
            armed_q    <= 1'b0;
            timer_irq  <= 1'b0;
        end else begin
            // writing Count restarts the prescaler
            if (wr_count) begin
                count      <= cp0_wdata;
                prescale_q <= '0;
            end else if (tick) begin
                count      <= count + 32'd1;
                prescale_q <= '0;
            end else begin
                prescale_q <= prescale_q + 1'b1;
            end
            // match only counts once Compare has been written
            if (compare_write) begin
                compare_q <= cp0_wdata;
                armed_q   <= 1'b1;
                timer_irq <= 1'b0;
            end else if (armed_q && tick && !wr_count && count == compare_q) begin
                timer_irq <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/exc_core.sv ====
`timescale 1ns/1ps

module exc_core
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       exc_instr,
    input  logic       exc_ri,
    input  logic       exc_of,
    input  logic       exc_sys,
    input  logic       exc_bp,
    input  logic       exc_load,
    input  logic       exc_save,
    input  word_t      pc,
    input  word_t      vaddr,
    input  logic       in_delay_slot,
    input  logic       eret,
    input  logic [5:0] hw_int,
    input  logic       cp0_we,
    input  logic [4:0] cp0_waddr,
    input  word_t      cp0_wdata,
    input  logic [4:0] cp0_raddr,
    output logic       redirect_valid,
    output word_t      redirect_pc,
    output logic       exc_taken,
    output exc_code_t  exc_code,
    output logic       flush,
    output word_t      cp0_rdata
);

    exception_t  exc_rec;
    cp0_status_t cp0_status;
    logic [7:0]  interrupt_info;
    word_t       epc;
    word_t       count;
    logic        timer_irq;
    logic        compare_write;
    logic        exc_commit;
    logic        eret_commit;

    exception u_exception (
        .exc_instr      (exc_instr),
        .exc_ri         (exc_ri),
        .exc_of         (exc_of),
        .exc_sys        (exc_sys),
        .exc_bp         (exc_bp),
        .exc_load       (exc_load),
        .exc_save       (exc_save),
        .pc             (pc),
        .vaddr          (vaddr),
        .in_delay_slot  (in_delay_slot),
        .interrupt_info (interrupt_info),
        .cp0_status     (cp0_status),
        .exception      (exc_rec)
    );

    exc_sequencer u_exc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .exception      (exc_rec),
        .eret           (eret),
        .exc_commit     (exc_commit),
        .eret_commit    (eret_commit),
        .exc_taken      (exc_taken),
        .exc_code       (exc_code),
        .redirect_valid (redirect_valid),
        .flush          (flush)
    );

    cp0_regs u_cp0_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .cp0_we         (cp0_we),
        .cp0_waddr      (cp0_waddr),
        .cp0_wdata      (cp0_wdata),
        .cp0_raddr      (cp0_raddr),
        .hw_int         (hw_int),
        .timer_irq      (timer_irq),
        .count          (count),
        .exc_commit     (exc_commit),
        .eret_commit    (eret_commit),
        .exception      (exc_rec),
        .cp0_rdata      (cp0_rdata),
        .cp0_status     (cp0_status),
        .interrupt_info (interrupt_info),
        .epc            (epc),
        .compare_write  (compare_write)
    );

    cp0_timer u_cp0_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .cp0_we         (cp0_we),
        .cp0_waddr      (cp0_waddr),
        .cp0_wdata      (cp0_wdata),
        .compare_write  (compare_write),
        .count          (count),
        .timer_irq      (timer_irq)
    );

    // exception entry wins, otherwise eret target
    assign redirect_pc = exc_taken ? exc_rec.location : epc;

endmodule

// ==== tb/exc_core_checker.sv ====
`timescale 1ns/1ps

module exc_core_checker (
    input logic clk,
    input logic rst_n,
    input logic redirect_valid,
    input logic flush,
    input logic exc_taken
);

    // read back by the testbench at the end of the run
    int unsigned failures = 0;

    // the drain cycle keeps flushing after a redirect
    assert property (@(posedge clk) disable iff (!rst_n) redirect_valid |=> flush)
        else begin
            $error("flush missing in the cycle after a redirect");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) redirect_valid |=> !redirect_valid)
        else begin
            $error("redirect_valid high in two cycles in a row");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) exc_taken |-> flush)
        else begin
            $error("exception taken without flush");
            failures++;
        end

    // nothing may leave the block while reset is held
    assert property (@(posedge clk) !rst_n |-> !(flush || redirect_valid || exc_taken))
        else begin
            $error("control output high during reset");
            failures++;
        end

endmodule

// ==== tb/exc_core_tb.sv ====
`timescale 1ns/1ps

`include "mips_exc_macros.svh"

module exc_core_tb
    import mips_exc_pkg::*;
();

    // rough cycle counts of each test, the run limit is twice their sum
    localparam int LEN_RESET     = 8;
    localparam int LEN_PRIORITY  = 24;
    localparam int LEN_RECORD    = 26;
    localparam int LEN_DRAIN     = 10;
    localparam int LEN_ERET      = 10;
    localparam int LEN_INTERRUPT = 16;
    localparam int LEN_TIMER     = 30;
    localparam int CYCLE_LIMIT   = 2 * (LEN_RESET + LEN_PRIORITY + LEN_RECORD + LEN_DRAIN
                                        + LEN_ERET + LEN_INTERRUPT + LEN_TIMER);

    // cause flag order {instr, ri, of, sys, bp, load, save}
    localparam logic [6:0] F_NONE  = 7'b0000000;
    localparam logic [6:0] F_INSTR = 7'b1000000;
    localparam logic [6:0] F_RI    = 7'b0100000;
    localparam logic [6:0] F_OF    = 7'b0010000;
    localparam logic [6:0] F_SYS   = 7'b0001000;
    localparam logic [6:0] F_BP    = 7'b0000100;
    localparam logic [6:0] F_LOAD  = 7'b0000010;
    localparam logic [6:0] F_SAVE  = 7'b0000001;

    localparam word_t TIMER_DELTA = 32'd4;

    logic       clk;
    logic       rst_n;
    logic       exc_instr;
    logic       exc_ri;
    logic       exc_of;
    logic       exc_sys;
    logic       exc_bp;
    logic       exc_load;
    logic       exc_save;
    word_t      pc;
    word_t      vaddr;
    logic       in_delay_slot;
    logic       eret;
    logic [5:0] hw_int;
    logic       cp0_we;
    logic [4:0] cp0_waddr;
    word_t      cp0_wdata;
    logic [4:0] cp0_raddr;
    logic       redirect_valid;
    word_t      redirect_pc;
    logic       exc_taken;
    exc_code_t  exc_code;
    logic       flush;
    word_t      cp0_rdata;

    word_t lcg_state = 32'd12591;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    cycle_count = 0;
    int    total_failures;

    exc_core u_exc_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .exc_instr      (exc_instr),
        .exc_ri         (exc_ri),
        .exc_of         (exc_of),
        .exc_sys        (exc_sys),
        .exc_bp         (exc_bp),
        .exc_load       (exc_load),
        .exc_save       (exc_save),
        .pc             (pc),
        .vaddr          (vaddr),
        .in_delay_slot  (in_delay_slot),
        .eret           (eret),
        .hw_int         (hw_int),
        .cp0_we         (cp0_we),
        .cp0_waddr      (cp0_waddr),
        .cp0_wdata      (cp0_wdata),
        .cp0_raddr      (cp0_raddr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exc_taken      (exc_taken),
        .exc_code       (exc_code),
        .flush          (flush),
        .cp0_rdata      (cp0_rdata)
    );

    bind exc_core exc_core_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .flush          (flush),
        .exc_taken      (exc_taken)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // fixed priority below the interrupt
    function automatic exc_code_t expected_code(input logic [6:0] flags, input logic int_ok);
        if (int_ok)
            return CODE_INT;
        if (flags[6])
            return CODE_ADEL;
        if (flags[5])
            return CODE_RI;
        if (flags[4])
            return CODE_OV;
        if (flags[3])
            return CODE_SYS;
        if (flags[2])
            return CODE_BP;
        if (flags[1])
            return CODE_ADEL;
        return CODE_ADES;
    endfunction

    // masked request, IE set, EXL and ERL clear
    function automatic logic interrupt_expected(input word_t status_w, input logic [7:0] pending);
        logic [7:0] masked;
        masked = pending & status_w[15:8];
        return (masked != 8'd0) && status_w[0] && !status_w[1] && !status_w[2];
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input exc_code_t got, input exc_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %-10s ok", name);
        end else begin
            $display("test %-10s %0d errors", name, errors - errs_before);
        end
    endtask

    // drives one cycle of inputs, returns at the falling edge for checks
    task automatic drive_event(input logic [6:0] flags, input logic eret_v, input word_t pc_v,
                               input word_t va_v, input logic ds, input logic [5:0] hw);
        @(posedge clk);
        {exc_instr, exc_ri, exc_of, exc_sys, exc_bp, exc_load, exc_save} <= flags;
        eret          <= eret_v;
        pc            <= pc_v;
        vaddr         <= va_v;
        in_delay_slot <= ds;
        hw_int        <= hw;
        @(negedge clk);
    endtask

    task automatic release_inputs();
        @(posedge clk);
        {exc_instr, exc_ri, exc_of, exc_sys, exc_bp, exc_load, exc_save} <= F_NONE;
        eret          <= 1'b0;
        in_delay_slot <= 1'b0;
        hw_int        <= 6'd0;
        @(negedge clk);
    endtask

    task automatic write_cp0(input logic [4:0] addr, input word_t data);
        @(posedge clk);
        cp0_we    <= 1'b1;
        cp0_waddr <= addr;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_we    <= 1'b0;
    endtask

    task automatic read_cp0(input logic [4:0] addr, output word_t data);
        @(posedge clk);
        cp0_raddr <= addr;
        @(negedge clk);
        data = cp0_rdata;
    endtask

    task automatic test_reset();
        int    errs_before;
        word_t rd;
        errs_before = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("flush", flush, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("exc_taken", exc_taken, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("flush", flush, 1'b0);
        read_cp0(`CP0_STATUS, rd);
        check_word("Status", rd, 32'h0000_0004);
        read_cp0(`CP0_COMPARE, rd);
        check_word("Compare", rd, 32'd0);
        read_cp0(`CP0_CAUSE, rd);
        check_bit("Cause.TI", rd[30], 1'b0);
        report_test("reset", errs_before);
    endtask

    task automatic test_priority();
        int         errs_before;
        logic [6:0] flags;
        word_t      tmp;
        errs_before = errors;
        for (int i = 0; i < 11; i++) begin
            tmp = lcg_next();
            flags = (i < 7) ? (7'h7F >> i) : (tmp[6:0] | F_SAVE);
            drive_event(flags, 1'b0, lcg_next(), lcg_next(), 1'b0, 6'd0);
            check_bit("exc_taken", exc_taken, 1'b1);
            check_code("exc_code", exc_code, expected_code(flags, 1'b0));
            check_bit("redirect_valid", redirect_valid, 1'b1);
            check_word("redirect_pc", redirect_pc, `EXC_ENTRY);
            check_bit("flush", flush, 1'b1);
            release_inputs();
            check_bit("flush", flush, 1'b1);
            check_bit("redirect_valid", redirect_valid, 1'b0);
        end
        report_test("priority", errs_before);
    endtask

    task automatic record_case(input logic [6:0] flags, input logic ds);
        word_t pc_v;
        word_t va_v;
        word_t rd;
        pc_v = lcg_next();
        va_v = lcg_next();
        drive_event(flags, 1'b0, pc_v, va_v, ds, 6'd0);
        check_bit("exc_taken", exc_taken, 1'b1);
        check_code("exc_code", exc_code, expected_code(flags, 1'b0));
        release_inputs();
        read_cp0(`CP0_EPC, rd);
        check_word("EPC", rd, ds ? (pc_v - 32'd4) : pc_v);
        read_cp0(`CP0_BADVADDR, rd);
        check_word("BadVAddr", rd, flags[6] ? pc_v : va_v);
        read_cp0(`CP0_CAUSE, rd);
        check_code("Cause.ExcCode", exc_code_t'(rd[6:2]), expected_code(flags, 1'b0));
        check_bit("Cause.BD", rd[31], ds);
        read_cp0(`CP0_STATUS, rd);
        check_bit("Status.EXL", rd[1], 1'b1);
    endtask

    task automatic test_recording();
        int errs_before;
        errs_before = errors;
        record_case(F_LOAD, 1'b0);
        record_case(F_SAVE, 1'b1);
        record_case(F_INSTR, 1'b0);
        record_case(F_INSTR, 1'b1);
        report_test("recording", errs_before);
    endtask

    task automatic test_drain();
        int    errs_before;
        word_t rd;
        errs_before = errors;
        drive_event(F_SYS, 1'b0, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_code("exc_code", exc_code, CODE_SYS);
        // second cause lands in the drain cycle
        drive_event(F_BP, 1'b0, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_bit("exc_taken", exc_taken, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("flush", flush, 1'b1);
        release_inputs();
        read_cp0(`CP0_STATUS, rd);
        check_bit("Status.EXL", rd[1], 1'b1);
        drive_event(F_OF, 1'b0, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_bit("exc_taken", exc_taken, 1'b1);
        check_code("exc_code", exc_code, CODE_OV);
        release_inputs();
        report_test("drain", errs_before);
    endtask

    task automatic test_eret();
        int    errs_before;
        word_t pc_v;
        word_t rd;
        errs_before = errors;
        pc_v = lcg_next();
        drive_event(F_SYS, 1'b0, pc_v, lcg_next(), 1'b0, 6'd0);
        release_inputs();
        drive_event(F_NONE, 1'b1, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_bit("redirect_valid", redirect_valid, 1'b1);
        check_word("redirect_pc", redirect_pc, pc_v);
        check_bit("flush", flush, 1'b1);
        check_bit("exc_taken", exc_taken, 1'b0);
        release_inputs();
        check_bit("flush", flush, 1'b1);
        read_cp0(`CP0_STATUS, rd);
        check_bit("Status.EXL", rd[1], 1'b0);
        // exception and eret together, exception wins
        drive_event(F_BP, 1'b1, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_bit("exc_taken", exc_taken, 1'b1);
        check_code("exc_code", exc_code, CODE_BP);
        check_word("redirect_pc", redirect_pc, `EXC_ENTRY);
        release_inputs();
        read_cp0(`CP0_STATUS, rd);
        check_bit("Status.EXL", rd[1], 1'b1);
        report_test("eret", errs_before);
    endtask

    task automatic interrupt_case(input word_t status_w, input logic [6:0] flags);
        logic int_ok;
        int_ok = interrupt_expected(status_w, {6'b000001, 2'b00});
        write_cp0(`CP0_STATUS, status_w);
        drive_event(flags, 1'b0, lcg_next(), lcg_next(), 1'b0, 6'b000001);
        check_bit("exc_taken", exc_taken, int_ok | (flags != F_NONE));
        if (int_ok) begin
            check_code("exc_code", exc_code, expected_code(flags, int_ok));
        end
        release_inputs();
    endtask

    task automatic test_interrupt();
        int errs_before;
        errs_before = errors;
        // IM[2] carries hw_int[0], the reserved instruction loses to it
        interrupt_case(32'h0000_0401, F_RI);
        interrupt_case(32'h0000_0400, F_NONE);
        interrupt_case(32'h0000_0403, F_NONE);
        report_test("interrupt", errs_before);
    endtask

    task automatic test_timer();
        int    errs_before;
        int    waited;
        int    bound;
        logic  seen;
        word_t rd;
        errs_before = errors;
        bound = (TIMER_DELTA + 2) * `COUNT_PRESCALE + 4;
        write_cp0(`CP0_STATUS, 32'h0000_8001);
        read_cp0(`CP0_COUNT, rd);
        write_cp0(`CP0_COMPARE, rd + TIMER_DELTA);
        @(posedge clk);
        cp0_raddr <= `CP0_CAUSE;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < bound) begin
            @(negedge clk);
            if (exc_taken) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (seen) begin
            check_code("exc_code", exc_code, CODE_INT);
            check_bit("Cause.TI", cp0_rdata[30], 1'b1);
        end else begin
            errors++;
            $display("timer interrupt not taken within %0d cycles", bound);
        end
        write_cp0(`CP0_COMPARE, rd + 32'd1000);
        read_cp0(`CP0_CAUSE, rd);
        check_bit("Cause.TI", rd[30], 1'b0);
        drive_event(F_NONE, 1'b1, lcg_next(), lcg_next(), 1'b0, 6'd0);
        check_bit("redirect_valid", redirect_valid, 1'b1);
        release_inputs();
        read_cp0(`CP0_STATUS, rd);
        check_bit("Status.EXL", rd[1], 1'b0);
        check_bit("exc_taken", exc_taken, 1'b0);
        report_test("timer", errs_before);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        exc_instr     = 1'b0;
        exc_ri        = 1'b0;
        exc_of        = 1'b0;
        exc_sys       = 1'b0;
        exc_bp        = 1'b0;
        exc_load      = 1'b0;
        exc_save      = 1'b0;
        pc            = '0;
        vaddr         = '0;
        in_delay_slot = 1'b0;
        eret          = 1'b0;
        hw_int        = 6'd0;
        cp0_we        = 1'b0;
        cp0_waddr     = 5'd0;
        cp0_wdata     = '0;
        cp0_raddr     = 5'd0;
        test_reset();
        test_priority();
        test_recording();
        test_drain();
        test_eret();
        test_interrupt();
        test_timer();
        total_failures = errors + u_exc_core.u_checker.failures;
        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 tests, checks, errors, u_exc_core.u_checker.failures);
        if (total_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/mips_exc_pkg.sv
exception/exception.sv
exception/exc_sequencer.sv
cp0/cp0_regs.sv
cp0/cp0_timer.sv
rtl/exc_core.sv
tb/exc_core_checker.sv
tb/exc_core_tb.sv
